/* design/dekatronPkg.sv */
package dekatronPkg;

    // **************************************************************************
    // Front-panel keyboard.
    // **************************************************************************
    localparam int unsigned keyCount = 40;

    typedef logic [keyCount-1:0] keyState_t;  // Bit i is high while key i is held.

    // Counter selection keys.
    localparam int unsigned keyIp   = 0;
    localparam int unsigned keyAp   = 1;
    localparam int unsigned keyLoop = 2;
    localparam int unsigned keyData = 3;

    // Machine control keys.
    localparam int unsigned keyHardRst = 8;
    localparam int unsigned keySoftRst = 9;
    localparam int unsigned keyHalt    = 10;
    localparam int unsigned keyStep    = 11;
    localparam int unsigned keyRun     = 12;

    // Edit keys act on the selected counter, the arrows on the instruction pointer.
    localparam int unsigned keyInc        = 16;
    localparam int unsigned keyDec        = 17;
    localparam int unsigned keyArrowUp    = 20;
    localparam int unsigned keyArrowDown  = 21;
    localparam int unsigned keyArrowLeft  = 22;
    localparam int unsigned keyArrowRight = 23;

    // **************************************************************************
    // State encodings.
    // **************************************************************************
    typedef enum logic [2:0] {
        selNone = 3'd0,
        selIp   = 3'd1,
        selAp   = 3'd2,
        selLoop = 3'd3,
        selData = 3'd4
    } counterSel_e;

    typedef enum logic [2:0] {
        stHardRst = 3'd0,
        stSoftRst = 3'd1,
        stHalt    = 3'd2,
        stStep    = 3'd3,
        stRun     = 3'd4
    } machineState_e;

    // **************************************************************************
    // IN-12 indicator tubes.
    // **************************************************************************
    typedef logic [3:0] hexDigit_t;
    typedef logic [3:0] digitPins_t;

    // The tube's cathodes are not wired in digit order.
    function automatic digitPins_t cathodePins(input hexDigit_t digit);
        case (digit)
            4'd0: cathodePins = 4'd1;
            4'd1: cathodePins = 4'd0;
            4'd2: cathodePins = 4'd2;
            4'd3: cathodePins = 4'd3;
            4'd4: cathodePins = 4'd6;
            4'd5: cathodePins = 4'd8;
            4'd6: cathodePins = 4'd9;
            4'd7: cathodePins = 4'd7;
            4'd8: cathodePins = 4'd5;
            4'd9: cathodePins = 4'd4;
            default: cathodePins = 4'd10;  // No cathode lit.
        endcase
    endfunction

endpackage

/* design/keyEdgeDetect.sv */
`timescale 1ns/10ps

module keyEdgeDetect import dekatronPkg::*; (
    input  logic      Clk,
    input  logic      Rst_n,
    input  keyState_t keys,
    output logic      stepPulse,
    output logic      incPulse,
    output logic      decPulse,
    output logic      upPulse,
    output logic      downPulse,
    output logic      leftPulse,
    output logic      rightPulse
);

    logic [6:0] edgeKeys;
    logic [6:0] prevKeys;
    logic [6:0] pulses;

    assign edgeKeys = {keys[keyStep], keys[keyInc], keys[keyDec], keys[keyArrowUp],
                       keys[keyArrowDown], keys[keyArrowLeft], keys[keyArrowRight]};

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            prevKeys <= '0;
        end else begin
            prevKeys <= edgeKeys;
        end
    end

    assign pulses = edgeKeys & ~prevKeys;  // Held now, released at the last edge.

    assign {stepPulse, incPulse, decPulse, upPulse, downPulse, leftPulse, rightPulse} = pulses;

endmodule

/* design/counterSelect.sv */
`timescale 1ns/10ps

module counterSelect import dekatronPkg::*; (
    input  logic        Clk,
    input  logic        Rst_n,
    input  keyState_t   keys,
    output counterSel_e selected
);

    counterSel_e nextSel;

    // The selection keys are levels, so holding one simply keeps the choice.
    // A key for the counter already selected is skipped, which lets a lower
    // priority key take over while both are held.
    always_comb begin
        nextSel = selected;
        case (selected)
            selIp: begin
                if (keys[keyAp]) nextSel = selAp;
                else if (keys[keyLoop]) nextSel = selLoop;
                else if (keys[keyData]) nextSel = selData;
            end
            selAp: begin
                if (keys[keyIp]) nextSel = selIp;
                else if (keys[keyLoop]) nextSel = selLoop;
                else if (keys[keyData]) nextSel = selData;
            end
            selLoop: begin
                if (keys[keyIp]) nextSel = selIp;
                else if (keys[keyAp]) nextSel = selAp;
                else if (keys[keyData]) nextSel = selData;
            end
            selData: begin
                if (keys[keyIp]) nextSel = selIp;
                else if (keys[keyAp]) nextSel = selAp;
                else if (keys[keyLoop]) nextSel = selLoop;
            end
            default: begin
                if (keys[keyIp]) nextSel = selIp;
                else if (keys[keyAp]) nextSel = selAp;
                else if (keys[keyLoop]) nextSel = selLoop;
                else if (keys[keyData]) nextSel = selData;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            selected <= selNone;
        end else begin
            selected <= nextSel;
        end
    end

endmodule

/* design/machineControl.sv */
`timescale 1ns/10ps

module machineControl import dekatronPkg::*; (
    input  logic          Clk,
    input  logic          Rst_n,
    input  keyState_t     keys,
    input  logic          stepPulse,
    output machineState_e machineState
);

    machineState_e nextState;

    logic hardRstKey;
    logic softRstKey;
    logic haltKey;
    logic runKey;

    assign hardRstKey = keys[keyHardRst];
    assign softRstKey = keys[keySoftRst];
    assign haltKey    = keys[keyHalt];
    assign runKey     = keys[keyRun];

    // **************************************************************************
    // Next state.
    // **************************************************************************
    always_comb begin
        case (machineState)
            stHardRst: begin
                if (softRstKey) nextState = stSoftRst;
                else if (stepPulse) nextState = stStep;
                else if (runKey) nextState = stRun;
                else nextState = stHalt;
            end
            stSoftRst: begin
                if (hardRstKey) nextState = stHardRst;
                else if (stepPulse) nextState = stStep;
                else if (runKey) nextState = stRun;
                else nextState = stHalt;
            end
            stStep: begin
                // A held step key gives no second pulse, so one step per press.
                if (hardRstKey) nextState = stHardRst;
                else if (softRstKey) nextState = stSoftRst;
                else if (runKey) nextState = stRun;
                else nextState = stHalt;
            end
            stRun: begin
                if (hardRstKey) nextState = stHardRst;
                else if (softRstKey) nextState = stSoftRst;
                else if (haltKey) nextState = stHalt;
                else if (stepPulse) nextState = stStep;
                else nextState = stRun;
            end
            stHalt: begin
                if (hardRstKey) nextState = stHardRst;
                else if (softRstKey) nextState = stSoftRst;
                else if (stepPulse) nextState = stStep;
                else if (runKey) nextState = stRun;
                else nextState = stHalt;
            end
            default: nextState = stHalt;
        endcase
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            machineState <= stHardRst;
        end else begin
            machineState <= nextState;
        end
    end

endmodule

/* design/registerBank.sv */
`timescale 1ns/10ps

module registerBank import dekatronPkg::*; #(
    parameter int IpWidth   = 18,
    parameter int ApWidth   = 15,
    parameter int LoopWidth = 9,
    parameter int DataWidth = 9
) (
    input  logic                 Clk,
    input  logic                 Rst_n,
    input  machineState_e        machineState,
    input  counterSel_e          selected,
    input  logic                 incPulse,
    input  logic                 decPulse,
    input  logic                 upPulse,
    input  logic                 downPulse,
    input  logic                 leftPulse,
    input  logic                 rightPulse,
    output logic [IpWidth-1:0]   ipCounter,
    output logic [ApWidth-1:0]   apCounter,
    output logic [LoopWidth-1:0] loopCounter,
    output logic [DataWidth-1:0] dataCounter
);

    localparam logic [IpWidth-1:0] IpOne = IpWidth'(1);
    localparam logic [IpWidth-1:0] IpRow = IpWidth'(16);  // One display row.

    logic inReset;
    logic advancing;
    logic ipSelected;

    assign inReset    = (machineState == stHardRst) || (machineState == stSoftRst);
    assign advancing  = (machineState == stStep) || (machineState == stRun);
    assign ipSelected = (selected == selIp);

    // **************************************************************************
    // Counters. Only one operator edit lands per cycle.
    // **************************************************************************
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            ipCounter   <= '0;
            apCounter   <= '0;
            loopCounter <= '0;
            dataCounter <= '0;
        end else if (inReset) begin
            ipCounter   <= '0;
            apCounter   <= '0;
            loopCounter <= '0;
            dataCounter <= '0;
        end else if (advancing) begin
            ipCounter <= ipCounter + IpOne;
        end else if (machineState == stHalt) begin
            if (incPulse) begin
                case (selected)
                    selIp:   ipCounter   <= ipCounter + IpOne;
                    selAp:   apCounter   <= apCounter + ApWidth'(1);
                    selLoop: loopCounter <= loopCounter + LoopWidth'(1);
                    selData: dataCounter <= dataCounter + DataWidth'(1);
                    default: ;  // Nothing selected yet.
                endcase
            end else if (decPulse) begin
                case (selected)
                    selIp:   ipCounter   <= ipCounter - IpOne;
                    selAp:   apCounter   <= apCounter - ApWidth'(1);
                    selLoop: loopCounter <= loopCounter - LoopWidth'(1);
                    selData: dataCounter <= dataCounter - DataWidth'(1);
                    default: ;
                endcase
            end else if (upPulse && ipSelected) begin
                ipCounter <= ipCounter - IpRow;
            end else if (downPulse && ipSelected) begin
                ipCounter <= ipCounter + IpRow;
            end else if (leftPulse && ipSelected) begin
                ipCounter <= ipCounter - IpOne;
            end else if (rightPulse && ipSelected) begin
                ipCounter <= ipCounter + IpOne;
            end
        end
    end

endmodule

/* design/nixieDecoder.sv */
`timescale 1ns/10ps

module nixieDecoder import dekatronPkg::*; #(
    parameter int IpWidth = 18
) (
    input  logic [IpWidth-1:0] ipCounter,
    output logic [15:0]        ipDigitPins
);

    localparam int TubeCount = 4;

    // Tube 0 shows the lowest hex digit of the pointer.
    for (genvar tube = 0; tube < TubeCount; tube++) begin : gTube
        hexDigit_t  digit;
        digitPins_t pins;

        assign digit = ipCounter[4*tube +: 4];
        assign pins  = cathodePins(digit);  // Digits A to F blank the tube.

        assign ipDigitPins[4*tube +: 4] = pins;
    end

endmodule

/* design/dekatronPc.sv */
`timescale 1ns/10ps

module dekatronPc import dekatronPkg::*; #(
    parameter int IpWidth   = 18,
    parameter int ApWidth   = 15,
    parameter int LoopWidth = 9,
    parameter int DataWidth = 9
) (
    input  logic                 Clk,
    input  logic                 Rst_n,
    input  keyState_t            keys,
    output logic [IpWidth-1:0]   ipCounter,
    output logic [ApWidth-1:0]   apCounter,
    output logic [LoopWidth-1:0] loopCounter,
    output logic [DataWidth-1:0] dataCounter,
    output machineState_e        machineState,
    output logic [15:0]          ipDigitPins
);

    logic        stepPulse;
    logic        incPulse;
    logic        decPulse;
    logic        upPulse;
    logic        downPulse;
    logic        leftPulse;
    logic        rightPulse;
    counterSel_e selected;

    keyEdgeDetect u_keyEdgeDetect (
        .Clk        (Clk),
        .Rst_n      (Rst_n),
        .keys       (keys),
        .stepPulse  (stepPulse),
        .incPulse   (incPulse),
        .decPulse   (decPulse),
        .upPulse    (upPulse),
        .downPulse  (downPulse),
        .leftPulse  (leftPulse),
        .rightPulse (rightPulse)
    );

    counterSelect u_counterSelect (
        .Clk      (Clk),
        .Rst_n    (Rst_n),
        .keys     (keys),
        .selected (selected)
    );

    machineControl u_machineControl (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .keys         (keys),
        .stepPulse    (stepPulse),
        .machineState (machineState)
    );

    registerBank #(
        .IpWidth   (IpWidth),
        .ApWidth   (ApWidth),
        .LoopWidth (LoopWidth),
        .DataWidth (DataWidth)
    ) u_registerBank (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .machineState (machineState),
        .selected     (selected),
        .incPulse     (incPulse),
        .decPulse     (decPulse),
        .upPulse      (upPulse),
        .downPulse    (downPulse),
        .leftPulse    (leftPulse),
        .rightPulse   (rightPulse),
        .ipCounter    (ipCounter),
        .apCounter    (apCounter),
        .loopCounter  (loopCounter),
        .dataCounter  (dataCounter)
    );

    nixieDecoder #(
        .IpWidth (IpWidth)
    ) u_nixieDecoder (
        .ipCounter   (ipCounter),
        .ipDigitPins (ipDigitPins)
    );

endmodule

/* testbench/dekatronPc_checker.sv */
`timescale 1ns/10ps

module dekatronPc_checker import dekatronPkg::*; #(
    parameter int IpWidth   = 18,
    parameter int ApWidth   = 15,
    parameter int LoopWidth = 9,
    parameter int DataWidth = 9
) (
    input logic                 Clk,
    input logic                 Rst_n,
    input machineState_e        machineState,
    input counterSel_e          selected,
    input logic                 incPulse,
    input logic [IpWidth-1:0]   ipCounter,
    input logic [ApWidth-1:0]   apCounter,
    input logic [LoopWidth-1:0] loopCounter,
    input logic [DataWidth-1:0] dataCounter
);

    int unsigned failCount = 0;  // Number of failed assertions so far.

    logic inReset;
    logic editInHalt;

    assign inReset    = (machineState == stHardRst) || (machineState == stSoftRst);
    assign editInHalt = (machineState == stHalt) && incPulse;

    // **************************************************************************
    // Machine states.
    // **************************************************************************
    resetClears: assert property (@(posedge Clk) disable iff (!Rst_n)
        inReset |=> (ipCounter == '0) && (apCounter == '0) &&
                    (loopCounter == '0) && (dataCounter == '0))
    else begin
        failCount++;
        $error("counters were not cleared after a reset state");
    end

    pointerAdvances: assert property (@(posedge Clk) disable iff (!Rst_n)
        (machineState == stStep) || (machineState == stRun)
            |=> ipCounter == $past(ipCounter) + IpWidth'(1))
    else begin
        failCount++;
        $error("instruction pointer did not advance by one in step or run");
    end

    // **************************************************************************
    // Operator increments in halt.
    // **************************************************************************
    incIp: assert property (@(posedge Clk) disable iff (!Rst_n)
        editInHalt && (selected == selIp) |=> ipCounter == $past(ipCounter) + IpWidth'(1))
    else begin
        failCount++;
        $error("inc key did not add one to the instruction pointer");
    end

    incAp: assert property (@(posedge Clk) disable iff (!Rst_n)
        editInHalt && (selected == selAp) |=> apCounter == $past(apCounter) + ApWidth'(1))
    else begin
        failCount++;
        $error("inc key did not add one to the address pointer");
    end

    incLoop: assert property (@(posedge Clk) disable iff (!Rst_n)
        editInHalt && (selected == selLoop)
            |=> loopCounter == $past(loopCounter) + LoopWidth'(1))
    else begin
        failCount++;
        $error("inc key did not add one to the loop counter");
    end

    incData: assert property (@(posedge Clk) disable iff (!Rst_n)
        editInHalt && (selected == selData)
            |=> dataCounter == $past(dataCounter) + DataWidth'(1))
    else begin
        failCount++;
        $error("inc key did not add one to the data counter");
    end

endmodule

bind dekatronPc dekatronPc_checker #(
    .IpWidth   (IpWidth),
    .ApWidth   (ApWidth),
    .LoopWidth (LoopWidth),
    .DataWidth (DataWidth)
) u_checker (
    .Clk          (Clk),
    .Rst_n        (Rst_n),
    .machineState (machineState),
    .selected     (selected),
    .incPulse     (incPulse),
    .ipCounter    (ipCounter),
    .apCounter    (apCounter),
    .loopCounter  (loopCounter),
    .dataCounter  (dataCounter)
);

/* testbench/dekatronPcTb.sv */
`timescale 1ns/10ps

module dekatronPcTb import dekatronPkg::*; ();

    localparam int IpWidth   = 18;
    localparam int ApWidth   = 15;
    localparam int LoopWidth = 9;
    localparam int DataWidth = 9;

    localparam int ResetCycles = 8;
    localparam int PressCycles = 3;  // Wait for a falling edge, then hold for two cycles.
    localparam int MaxEdits    = 7;
    localparam int MaxRun      = 40;
    localparam int TimeoutCycles = ResetCycles + 2 + 4 * (MaxEdits + 3) * PressCycles
                                 + 10 * PressCycles + 5 + (MaxRun + 6) + 4 + 100;

    logic                 Clk = 1'b0;
    logic                 Rst_n;
    keyState_t            keys;
    logic [IpWidth-1:0]   ipCounter;
    logic [ApWidth-1:0]   apCounter;
    logic [LoopWidth-1:0] loopCounter;
    logic [DataWidth-1:0] dataCounter;
    machineState_e        machineState;
    logic [15:0]          ipDigitPins;

    // Reference model of the counters and the selection.
    logic [IpWidth-1:0]   ipModel;
    logic [ApWidth-1:0]   apModel;
    logic [LoopWidth-1:0] loopModel;
    logic [DataWidth-1:0] dataModel;
    counterSel_e          selModel;

    int unsigned lcgState = 13;
    int          errorCount = 0;
    int          testCount = 0;
    int          failedTests = 0;

    always #2 Clk = ~Clk;

    dekatronPc #(
        .IpWidth   (IpWidth),
        .ApWidth   (ApWidth),
        .LoopWidth (LoopWidth),
        .DataWidth (DataWidth)
    ) u_dut (
        .Clk          (Clk),
        .Rst_n        (Rst_n),
        .keys         (keys),
        .ipCounter    (ipCounter),
        .apCounter    (apCounter),
        .loopCounter  (loopCounter),
        .dataCounter  (dataCounter),
        .machineState (machineState),
        .ipDigitPins  (ipDigitPins)
    );

    // **************************************************************************
    // Helpers.
    // **************************************************************************
    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;
    endfunction

    task automatic checkValue(input string testName, input int unsigned expected,
                              input int unsigned actual);
        assert (expected == actual) else begin
            errorCount++;
            $display("mismatch %s: expected 'h%0h, actual 'h%0h", testName, expected, actual);
        end
    endtask

    task automatic checkCounters(input string testName);
        checkValue(testName, 32'(ipModel), 32'(ipCounter));
        checkValue(testName, 32'(apModel), 32'(apCounter));
        checkValue(testName, 32'(loopModel), 32'(loopCounter));
        checkValue(testName, 32'(dataModel), 32'(dataCounter));
    endtask

    task automatic pressKey(input int unsigned key);
        @(negedge Clk);
        keys[key] = 1'b1;
        repeat (2) @(negedge Clk);
        keys[key] = 1'b0;
    endtask

    // Expected effect of one edit key pressed while the machine is halted.
    task automatic modelEdit(input int unsigned key);
        int delta;
        delta = 0;
        if (key == keyInc) delta = 1;
        else if (key == keyDec) delta = -1;
        if (delta != 0) begin
            case (selModel)
                selIp:   ipModel   = ipModel + IpWidth'(delta);
                selAp:   apModel   = apModel + ApWidth'(delta);
                selLoop: loopModel = loopModel + LoopWidth'(delta);
                selData: dataModel = dataModel + DataWidth'(delta);
                default: ;
            endcase
        end else if (selModel == selIp) begin
            if (key == keyArrowUp) ipModel = ipModel - IpWidth'(16);
            else if (key == keyArrowDown) ipModel = ipModel + IpWidth'(16);
            else if (key == keyArrowLeft) ipModel = ipModel - IpWidth'(1);
            else if (key == keyArrowRight) ipModel = ipModel + IpWidth'(1);
        end
    endtask

    task automatic editKey(input string testName, input int unsigned key);
        pressKey(key);
        modelEdit(key);
        checkCounters(testName);
    endtask

    task automatic reportTest(input string testName, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s: passed", testName);
        end else begin
            failedTests++;
            $display("test %s: failed with %0d errors", testName, errorCount - errorsBefore);
        end
    endtask

    task automatic editTest(input string testName, input int unsigned selKey,
                            input counterSel_e sel);
        int edits;
        int errorsBefore;
        errorsBefore = errorCount;
        // An odd count leaves the counter nonzero for the soft reset.
        edits = 1 + 2 * (nextRandom() % ((MaxEdits + 1) / 2));
        pressKey(selKey);
        selModel = sel;
        editKey(testName, keyDec);  // The counter starts at zero, so this wraps.
        editKey(testName, keyInc);
        repeat (edits) begin
            editKey(testName, (nextRandom() % 2 == 0) ? keyInc : keyDec);
        end
        reportTest(testName, errorsBefore);
    endtask

    // Every tube shows the cathode code of its nibble, blank for A to F.
    always @(negedge Clk) begin
        logic [15:0] expectedPins;
        if (Rst_n === 1'b1) begin
            for (int tube = 0; tube < 4; tube++) begin
                expectedPins[4*tube +: 4] = cathodePins(ipCounter[4*tube +: 4]);
            end
            assert (ipDigitPins == expectedPins) else begin
                errorCount++;
                $display("mismatch display: expected 'h%0h, actual 'h%0h",
                         expectedPins, ipDigitPins);
            end
        end
    end

    initial begin
        repeat (TimeoutCycles) @(posedge Clk);
        $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // **************************************************************************
    // Test sequence.
    // **************************************************************************
    initial begin
        int errorsBefore;
        int runLength;
        int checkerFails;
        Rst_n = 1'b0;
        keys = '0;
        ipModel = '0;
        apModel = '0;
        loopModel = '0;
        dataModel = '0;
        selModel = selNone;
        repeat (ResetCycles) @(negedge Clk);
        Rst_n = 1'b1;

        errorsBefore = errorCount;
        checkValue("powerOnReset", 32'(stHardRst), 32'(machineState));
        checkCounters("powerOnReset");
        @(negedge Clk);
        checkValue("powerOnReset", 32'(stHalt), 32'(machineState));
        checkCounters("powerOnReset");
        reportTest("powerOnReset", errorsBefore);

        editTest("editIp", keyIp, selIp);
        editTest("editAp", keyAp, selAp);
        editTest("editLoop", keyLoop, selLoop);
        editTest("editData", keyData, selData);

        errorsBefore = errorCount;
        pressKey(keyIp);
        selModel = selIp;
        editKey("arrows", keyArrowUp);
        editKey("arrows", keyArrowDown);
        editKey("arrows", keyArrowLeft);
        editKey("arrows", keyArrowRight);
        pressKey(keyAp);
        selModel = selAp;
        editKey("arrows", keyArrowUp);
        editKey("arrows", keyArrowDown);
        editKey("arrows", keyArrowLeft);
        editKey("arrows", keyArrowRight);
        reportTest("arrows", errorsBefore);

        // The step key stays held for several cycles but gives one step only.
        errorsBefore = errorCount;
        @(negedge Clk);
        keys[keyStep] = 1'b1;
        @(negedge Clk);
        checkValue("step", 32'(stStep), 32'(machineState));
        checkCounters("step");
        ipModel = ipModel + IpWidth'(1);  // The step cycle advances the pointer once.
        repeat (3) begin
            @(negedge Clk);
            checkValue("step", 32'(stHalt), 32'(machineState));
            checkCounters("step");
        end
        keys[keyStep] = 1'b0;
        reportTest("step", errorsBefore);

        errorsBefore = errorCount;
        runLength = 8 + nextRandom() % (MaxRun - 7);
        @(negedge Clk);
        keys[keyRun] = 1'b1;
        @(negedge Clk);
        keys[keyRun] = 1'b0;
        checkValue("run", 32'(stRun), 32'(machineState));
        checkCounters("run");
        repeat (runLength) begin
            @(negedge Clk);
            ipModel = ipModel + IpWidth'(1);
            checkValue("run", 32'(stRun), 32'(machineState));
            checkCounters("run");
        end
        keys[keyHalt] = 1'b1;
        @(negedge Clk);
        keys[keyHalt] = 1'b0;
        ipModel = ipModel + IpWidth'(1);  // The edge that halts still advances.
        checkValue("run", 32'(stHalt), 32'(machineState));
        repeat (3) begin
            @(negedge Clk);
            checkCounters("run");
        end
        reportTest("run", errorsBefore);

        errorsBefore = errorCount;
        @(negedge Clk);
        keys[keySoftRst] = 1'b1;
        @(negedge Clk);
        checkValue("softReset", 32'(stSoftRst), 32'(machineState));
        checkCounters("softReset");
        @(negedge Clk);
        keys[keySoftRst] = 1'b0;
        ipModel = '0;
        apModel = '0;
        loopModel = '0;
        dataModel = '0;
        checkValue("softReset", 32'(stHalt), 32'(machineState));
        checkCounters("softReset");
        reportTest("softReset", errorsBefore);

        @(negedge Clk);
        checkerFails = int'(u_dut.u_checker.failCount);
        $display("tests: %0d, failed tests: %0d, errors: %0d, assertion failures: %0d",
                 testCount, failedTests, errorCount, checkerFails);
        if (errorCount == 0 && checkerFails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* dekatronPc.f */
design/dekatronPkg.sv
design/keyEdgeDetect.sv
design/counterSelect.sv
design/machineControl.sv
design/registerBank.sv
design/nixieDecoder.sv
design/dekatronPc.sv
testbench/dekatronPc_checker.sv
testbench/dekatronPcTb.sv

/* run.sh */
#!/bin/sh
# Builds the dekatronPc testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dekatronPcTb -f dekatronPc.f -o dekatronPcSim
if [ $? -ne 0 ]; then
    echo "Build failed."
    exit 1
fi

./obj_dir/dekatronPcSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG."
exit 1
